// ==== Bender.yml ====
package:
  name: lc_sec_subsys

sources:
  - logic/lc_sec_pkg.sv
  - logic/dbg_mask_regs.sv
  - logic/fatal_err_latch.sv
  - logic/lc_sec_state_translator.sv
  - logic/lc_sec_subsys_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_lc_sec_subsys.sv

// ==== flist.f ====
+incdir+test
logic/lc_sec_pkg.sv
logic/dbg_mask_regs.sv
logic/fatal_err_latch.sv
logic/lc_sec_state_translator.sv
logic/lc_sec_subsys_top.sv
test/tb_lc_sec_subsys.sv

// ==== logic/dbg_mask_regs.sv ====
// SoC-written unlock mask and fatal enable registers with the unlock-hit reductions
module dbg_mask_regs
    import lc_sec_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  mask_wr_t                 mask_wr_i,
    input  logic [UNLOCK_W-1:0]      unlock_level_i,
    output unlock_hits_t             hits_o,
    output logic [NUM_FATAL_SRC-1:0] fatal_en_o
);

    logic [UNLOCK_W-1:0]      dft_mask_q;
    logic [UNLOCK_W-1:0]      dbg_mask_q;
    logic [UNLOCK_W-1:0]      cltap_mask_q;
    logic [NUM_FATAL_SRC-1:0] fatal_en_q;

    // Plain write strobe, value visible on the next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dft_mask_q   <= '0;
            dbg_mask_q   <= '0;
            cltap_mask_q <= '0;
            fatal_en_q   <= FATAL_EN_RST;
        end else if (mask_wr_i.en) begin
            case (mask_wr_i.addr)
                DFT_MASK_LO: begin
                    dft_mask_q[REG_W-1:0] <= mask_wr_i.data;
                end
                DFT_MASK_HI: begin
                    dft_mask_q[UNLOCK_W-1:REG_W] <= mask_wr_i.data;
                end
                DBG_MASK_LO: begin
                    dbg_mask_q[REG_W-1:0] <= mask_wr_i.data;
                end
                DBG_MASK_HI: begin
                    dbg_mask_q[UNLOCK_W-1:REG_W] <= mask_wr_i.data;
                end
                CLTAP_MASK_LO: begin
                    cltap_mask_q[REG_W-1:0] <= mask_wr_i.data;
                end
                CLTAP_MASK_HI: begin
                    cltap_mask_q[UNLOCK_W-1:REG_W] <= mask_wr_i.data;
                end
                FATAL_EN: begin
                    fatal_en_q <= mask_wr_i.data[NUM_FATAL_SRC-1:0];
                end
                default: begin
                    // Address 7 is unmapped
                end
            endcase
        end
    end

    // Any common bit between level and mask counts as a hit
    always_comb begin
        hits_o.dft   = |(unlock_level_i & dft_mask_q);
        hits_o.dbg   = |(unlock_level_i & dbg_mask_q);
        hits_o.cltap = |(unlock_level_i & cltap_mask_q);
    end

    assign fatal_en_o = fatal_en_q;

endmodule

// ==== logic/fatal_err_latch.sv ====
// Sticky enable-masked fatal error aggregation into the state error
module fatal_err_latch
    import lc_sec_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [NUM_FATAL_SRC-1:0] fatal_err_i,
    input  logic [NUM_FATAL_SRC-1:0] fatal_en_i,
    output logic                     state_error_o
);

    logic [NUM_FATAL_SRC-1:0] err_seen_q;
    logic [NUM_FATAL_SRC-1:0] err_masked;

    // Disabled sources never reach the record
    assign err_masked = fatal_err_i & fatal_en_i;

    // Per-source record, only reset clears it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_seen_q <= '0;
        end else begin
            err_seen_q <= err_seen_q | err_masked;
        end
    end

    assign state_error_o = |err_seen_q;

endmodule

// ==== logic/lc_sec_pkg.sv ====
// Lifecycle, translator and register enums, security state and OTP structs, shared localparams
package lc_sec_pkg;

    localparam int unsigned UNLOCK_W      = 64;
    localparam int unsigned REG_W         = 32;
    localparam int unsigned NUM_FATAL_SRC = 8;

    // All fatal sources enabled out of reset
    localparam logic [NUM_FATAL_SRC-1:0] FATAL_EN_RST = '1;

    // Static lifecycle state, plain binary encoding
    typedef enum logic [4:0] {
        LcStRaw           = 5'd0,
        LcStTestLocked0   = 5'd1,
        LcStTestLocked1   = 5'd2,
        LcStTestLocked2   = 5'd3,
        LcStTestLocked3   = 5'd4,
        LcStTestLocked4   = 5'd5,
        LcStTestLocked5   = 5'd6,
        LcStTestLocked6   = 5'd7,
        LcStTestUnlocked0 = 5'd8,
        LcStTestUnlocked1 = 5'd9,
        LcStTestUnlocked2 = 5'd10,
        LcStTestUnlocked3 = 5'd11,
        LcStTestUnlocked4 = 5'd12,
        LcStTestUnlocked5 = 5'd13,
        LcStTestUnlocked6 = 5'd14,
        LcStTestUnlocked7 = 5'd15,
        LcStDev           = 5'd16,
        LcStProd          = 5'd17,
        LcStProdEnd       = 5'd18,
        LcStRma           = 5'd19,
        LcStScrap         = 5'd20,
        LcStInvalid       = 5'd21
    } lc_state_e;

    // Multibit enable, any code other than On is treated as off
    typedef enum logic [3:0] {
        LcTxOn  = 4'b0101,
        LcTxOff = 4'b1010
    } lc_tx_e;

    typedef enum logic [2:0] {
        TRANSLATOR_RESET,
        TRANSLATOR_IDLE,
        TRANSLATOR_NON_DEBUG,
        TRANSLATOR_UNPROV_DEBUG,
        TRANSLATOR_MANUF_NON_DEBUG,
        TRANSLATOR_MANUF_DEBUG,
        TRANSLATOR_PROD_NON_DEBUG,
        TRANSLATOR_PROD_DEBUG
    } translator_state_e;

    typedef enum logic [1:0] {
        DEVICE_UNPROVISIONED = 2'b00,
        DEVICE_MANUFACTURING = 2'b01,
        DEVICE_PRODUCTION    = 2'b11
    } device_lifecycle_e;

    typedef struct packed {
        device_lifecycle_e device_lifecycle;
        logic              debug_locked;
    } security_state_t;

    localparam security_state_t SEC_STATE_LOCKED = '{
        device_lifecycle: DEVICE_PRODUCTION,
        debug_locked:     1'b1
    };

    typedef struct packed {
        logic      req;
        lc_state_e state;
    } otp_prog_req_t;

    typedef struct packed {
        logic      valid;
        lc_state_e state;
    } otp_prog_rsp_t;

    // Mask registers are 64 bits, written as two 32-bit halves
    typedef enum logic [2:0] {
        DFT_MASK_LO   = 3'd0,
        DFT_MASK_HI   = 3'd1,
        DBG_MASK_LO   = 3'd2,
        DBG_MASK_HI   = 3'd3,
        CLTAP_MASK_LO = 3'd4,
        CLTAP_MASK_HI = 3'd5,
        FATAL_EN      = 3'd6
    } mask_reg_addr_e;

    typedef struct packed {
        logic             en;
        mask_reg_addr_e   addr;
        logic [REG_W-1:0] data;
    } mask_wr_t;

    typedef struct packed {
        logic dft;
        logic dbg;
        logic cltap;
    } unlock_hits_t;

endpackage

// ==== logic/lc_sec_state_translator.sv ====
// Lifecycle to security state FSM, lc_tx decoding and registered SoC enables
module lc_sec_state_translator
    import lc_sec_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            state_error_i,
    input  otp_prog_req_t   otp_req_i,
    input  otp_prog_rsp_t   otp_rsp_i,
    input  lc_tx_e          lc_dft_en_i,
    input  lc_tx_e          lc_hw_debug_en_i,
    input  logic            manuf_dbg_en_i,
    input  unlock_hits_t    hits_i,
    output logic            soc_dft_en_o,
    output logic            soc_hw_debug_en_o,
    output security_state_t security_state_o
);

    translator_state_e state_q;
    translator_state_e state_d;
    lc_state_e         static_state_q;
    security_state_t   sec_state_dec;
    logic              scrap_cond;
    logic              dft_en_on;
    logic              hw_debug_en_on;

    // Alive state comes from the program request
    assign scrap_cond = state_error_i || (otp_req_i.req && (otp_req_i.state == LcStScrap));

    // Only the exact On code enables
    assign dft_en_on      = (lc_dft_en_i == LcTxOn);
    assign hw_debug_en_on = (lc_hw_debug_en_i == LcTxOn);

    // Static state taken once, on the first valid cycle
    always_ff @(posedge clk) begin
        if (otp_rsp_i.valid && (state_q == TRANSLATOR_RESET)) begin
            static_state_q <= otp_rsp_i.state;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            TRANSLATOR_RESET: begin
                state_d = TRANSLATOR_IDLE;
            end
            TRANSLATOR_IDLE: begin
                if (scrap_cond || (static_state_q == LcStScrap)) begin
                    state_d = TRANSLATOR_NON_DEBUG;
                end else begin
                    case (static_state_q)
                        LcStRaw,
                        LcStTestLocked0, LcStTestLocked1, LcStTestLocked2,
                        LcStTestLocked3, LcStTestLocked4, LcStTestLocked5,
                        LcStTestLocked6: begin
                            state_d = TRANSLATOR_NON_DEBUG;
                        end
                        LcStTestUnlocked0, LcStTestUnlocked1, LcStTestUnlocked2,
                        LcStTestUnlocked3, LcStTestUnlocked4, LcStTestUnlocked5,
                        LcStTestUnlocked6, LcStTestUnlocked7: begin
                            state_d = TRANSLATOR_UNPROV_DEBUG;
                        end
                        LcStDev: begin
                            state_d = TRANSLATOR_MANUF_NON_DEBUG;
                        end
                        LcStProd, LcStProdEnd: begin
                            state_d = TRANSLATOR_PROD_NON_DEBUG;
                        end
                        LcStRma: begin
                            state_d = TRANSLATOR_PROD_DEBUG;
                        end
                        default: begin
                            // Invalid waits here until valid drops
                            state_d = TRANSLATOR_IDLE;
                        end
                    endcase
                end
            end
            TRANSLATOR_NON_DEBUG: begin
                // Sink state
                state_d = TRANSLATOR_NON_DEBUG;
            end
            TRANSLATOR_MANUF_NON_DEBUG: begin
                if (scrap_cond) begin
                    state_d = TRANSLATOR_NON_DEBUG;
                end else if (manuf_dbg_en_i) begin
                    state_d = TRANSLATOR_MANUF_DEBUG;
                end
            end
            TRANSLATOR_PROD_NON_DEBUG: begin
                if (scrap_cond) begin
                    state_d = TRANSLATOR_NON_DEBUG;
                end else if (hits_i.dbg) begin
                    state_d = TRANSLATOR_PROD_DEBUG;
                end
            end
            default: begin
                // Unlocked states hold unless scrapped
                if (scrap_cond) begin
                    state_d = TRANSLATOR_NON_DEBUG;
                end
            end
        endcase
    end

    // Security state seen by the core for each translator state
    always_comb begin
        case (state_q)
            TRANSLATOR_UNPROV_DEBUG: begin
                sec_state_dec = '{device_lifecycle: DEVICE_UNPROVISIONED, debug_locked: 1'b0};
            end
            TRANSLATOR_MANUF_NON_DEBUG: begin
                sec_state_dec = '{device_lifecycle: DEVICE_MANUFACTURING, debug_locked: 1'b1};
            end
            TRANSLATOR_MANUF_DEBUG: begin
                sec_state_dec = '{device_lifecycle: DEVICE_MANUFACTURING, debug_locked: 1'b0};
            end
            TRANSLATOR_PROD_DEBUG: begin
                sec_state_dec = '{device_lifecycle: DEVICE_PRODUCTION, debug_locked: 1'b0};
            end
            default: begin
                sec_state_dec = SEC_STATE_LOCKED;
            end
        endcase
    end

    // Everything falls back to locked defaults while valid is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q           <= TRANSLATOR_RESET;
            security_state_o  <= SEC_STATE_LOCKED;
            soc_dft_en_o      <= 1'b0;
            soc_hw_debug_en_o <= 1'b0;
        end else if (otp_rsp_i.valid) begin
            state_q           <= state_d;
            security_state_o  <= sec_state_dec;
            soc_dft_en_o      <= dft_en_on | hits_i.dft;
            soc_hw_debug_en_o <= hw_debug_en_on | hits_i.cltap;
        end else begin
            state_q           <= TRANSLATOR_RESET;
            security_state_o  <= SEC_STATE_LOCKED;
            soc_dft_en_o      <= 1'b0;
            soc_hw_debug_en_o <= 1'b0;
        end
    end

endmodule

// ==== logic/lc_sec_subsys_top.sv ====
// Top level joining the mask register bank, fatal error latch and state translator
module lc_sec_subsys_top
    import lc_sec_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    // SoC register writes and security core level
    input  mask_wr_t                 mask_wr_i,
    input  logic [UNLOCK_W-1:0]      unlock_level_i,
    input  logic [NUM_FATAL_SRC-1:0] fatal_err_i,
    // Lifecycle and OTP controller fields
    input  otp_prog_req_t            otp_req_i,
    input  otp_prog_rsp_t            otp_rsp_i,
    input  lc_tx_e                   lc_dft_en_i,
    input  lc_tx_e                   lc_hw_debug_en_i,
    input  logic                     manuf_dbg_en_i,
    output logic                     soc_dft_en_o,
    output logic                     soc_hw_debug_en_o,
    output security_state_t          security_state_o,
    output logic                     state_error_o
);

    unlock_hits_t             hits;
    logic [NUM_FATAL_SRC-1:0] fatal_en;
    logic                     state_error;

    dbg_mask_regs mask_regs_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .mask_wr_i      (mask_wr_i),
        .unlock_level_i (unlock_level_i),
        .hits_o         (hits),
        .fatal_en_o     (fatal_en)
    );

    fatal_err_latch err_latch_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .fatal_err_i   (fatal_err_i),
        .fatal_en_i    (fatal_en),
        .state_error_o (state_error)
    );

    lc_sec_state_translator translator_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .state_error_i     (state_error),
        .otp_req_i         (otp_req_i),
        .otp_rsp_i         (otp_rsp_i),
        .lc_dft_en_i       (lc_dft_en_i),
        .lc_hw_debug_en_i  (lc_hw_debug_en_i),
        .manuf_dbg_en_i    (manuf_dbg_en_i),
        .hits_i            (hits),
        .soc_dft_en_o      (soc_dft_en_o),
        .soc_hw_debug_en_o (soc_hw_debug_en_o),
        .security_state_o  (security_state_o)
    );

    assign state_error_o = state_error;

endmodule

// ==== test/tb_lc_sec_ref.svh ====
// Reference functions for the settled security state and the SoC enables
`ifndef TB_LC_SEC_REF_SVH
`define TB_LC_SEC_REF_SVH

// Settled security state after the translator has reached its target
function automatic security_state_t expected_sec_state(
    input lc_state_e st,
    input logic      manuf_dbg_en,
    input logic      dbg_hit,
    input logic      err_or_scrap
);
    security_state_t res;
    res = '{device_lifecycle: DEVICE_PRODUCTION, debug_locked: 1'b1};
    if (err_or_scrap) begin
        return res;
    end
    if (st inside {[LcStTestUnlocked0:LcStTestUnlocked7]}) begin
        res = '{device_lifecycle: DEVICE_UNPROVISIONED, debug_locked: 1'b0};
    end else if (st == LcStDev) begin
        res = '{device_lifecycle: DEVICE_MANUFACTURING, debug_locked: !manuf_dbg_en};
    end else if ((st == LcStProd) || (st == LcStProdEnd)) begin
        // Prod unlocks only on a dbg mask hit
        res.debug_locked = !dbg_hit;
    end else if (st == LcStRma) begin
        res.debug_locked = 1'b0;
    end
    // Raw, TestLocked, Scrap and Invalid stay locked
    return res;
endfunction

// Returns {dft, hw_debug}, exact On code or the matching mask hit
function automatic logic [1:0] expected_soc_enables(
    input lc_tx_e dft_code,
    input lc_tx_e hw_code,
    input logic   dft_hit,
    input logic   cltap_hit
);
    logic dft_on;
    logic hw_on;
    dft_on = (dft_code === 4'b0101);
    hw_on  = (hw_code === 4'b0101);
    return {dft_on | dft_hit, hw_on | cltap_hit};
endfunction

`endif

// ==== test/tb_lc_sec_subsys.sv ====
// Testbench top with clock, reset, LFSR stimulus, compare process and report
module tb_lc_sec_subsys
    import lc_sec_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_lc_sec_ref.svh"

    logic                     clk;
    logic                     rst_n;
    mask_wr_t                 mask_wr;
    logic [UNLOCK_W-1:0]      unlock_level;
    logic [NUM_FATAL_SRC-1:0] fatal_err;
    otp_prog_req_t            otp_req;
    otp_prog_rsp_t            otp_rsp;
    lc_tx_e                   lc_dft_en;
    lc_tx_e                   lc_hw_debug_en;
    logic                     manuf_dbg_en;
    logic                     soc_dft_en;
    logic                     soc_hw_debug_en;
    security_state_t          security_state;
    logic                     state_error;

    // Testbench copies of the written registers
    logic [UNLOCK_W-1:0] dft_mask_m;
    logic [UNLOCK_W-1:0] dbg_mask_m;
    logic [UNLOCK_W-1:0] cltap_mask_m;
    logic                err_model;

    // Locked PRODUCTION with debug locked
    localparam security_state_t LOCKED_PROD = '{
        device_lifecycle: DEVICE_PRODUCTION,
        debug_locked:     1'b1
    };

    security_state_t exp_sec;
    logic            exp_dft;
    logic            exp_hw;
    logic            check_req;
    logic [15:0]     lfsr_q;
    int              err_count;
    int              err_mark;
    int              test_count;

    lc_sec_subsys_top dut_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .mask_wr_i         (mask_wr),
        .unlock_level_i    (unlock_level),
        .fatal_err_i       (fatal_err),
        .otp_req_i         (otp_req),
        .otp_rsp_i         (otp_rsp),
        .lc_dft_en_i       (lc_dft_en),
        .lc_hw_debug_en_i  (lc_hw_debug_en),
        .manuf_dbg_en_i    (manuf_dbg_en),
        .soc_dft_en_o      (soc_dft_en),
        .soc_hw_debug_en_o (soc_hw_debug_en),
        .security_state_o  (security_state),
        .state_error_o     (state_error)
    );

    always #20 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] res;
        res = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            res    = {res[62:0], lfsr_q[0]};
        end
        return res;
    endfunction

    task automatic check_sec_state(input security_state_t got, input security_state_t exp,
                                   input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s security state %b, expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_enable(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s enable %b, expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_error(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s state error %b, expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_locked(input string what);
        check_sec_state(security_state, LOCKED_PROD, what);
        check_enable(soc_dft_en, 1'b0, {what, " dft"});
        check_enable(soc_hw_debug_en, 1'b0, {what, " hw debug"});
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (err_count == err_mark) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    task automatic write_reg(input mask_reg_addr_e addr, input logic [REG_W-1:0] data);
        @(posedge clk);
        mask_wr <= '{en: 1'b1, addr: addr, data: data};
        @(posedge clk);
        mask_wr <= '0;
    endtask

    // Writes a 64-bit mask as two halves, low half first
    task automatic write_mask(input mask_reg_addr_e addr_lo, input logic [UNLOCK_W-1:0] value);
        write_reg(addr_lo, value[REG_W-1:0]);
        write_reg(mask_reg_addr_e'(addr_lo + 3'd1), value[UNLOCK_W-1:REG_W]);
        case (addr_lo)
            DFT_MASK_LO: dft_mask_m = value;
            DBG_MASK_LO: dbg_mask_m = value;
            default:     cltap_mask_m = value;
        endcase
    endtask

    // Raises valid with the given inputs and hands the expected values to the compare process
    task automatic run_case(input lc_state_e st, input logic manuf, input logic [63:0] level,
                            input lc_tx_e dcode, input lc_tx_e hcode);
        logic [1:0] en;
        int         n;
        @(posedge clk);
        otp_rsp        <= '{valid: 1'b1, state: st};
        otp_req        <= '0;
        manuf_dbg_en   <= manuf;
        unlock_level   <= level;
        lc_dft_en      <= dcode;
        lc_hw_debug_en <= hcode;
        exp_sec = expected_sec_state(st, manuf, |(level & dbg_mask_m), err_model);
        en      = expected_soc_enables(dcode, hcode, |(level & dft_mask_m),
                                       |(level & cltap_mask_m));
        exp_dft   = en[1];
        exp_hw    = en[0];
        check_req = 1'b1;
        n = 0;
        while (check_req && (n < 40)) begin
            @(posedge clk);
            n++;
        end
        if (check_req) begin
            $display("Timeout: the compare process never sampled the settled outputs");
            err_count++;
            check_req = 1'b0;
        end
    endtask

    // Drops valid and checks the locked defaults on the cycle after
    task automatic end_case();
        @(posedge clk);
        otp_rsp        <= '{valid: 1'b0, state: LcStRaw};
        otp_req        <= '0;
        unlock_level   <= '0;
        lc_dft_en      <= LcTxOff;
        lc_hw_debug_en <= LcTxOff;
        manuf_dbg_en   <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_locked("after valid drop");
    endtask

    task automatic wait_locked(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while ((security_state !== LOCKED_PROD) && (n < 10)) begin
            @(negedge clk);
            n++;
        end
        if (security_state !== LOCKED_PROD) begin
            $display("Timeout: security state never returned to locked after %s", what);
            err_count++;
        end
    endtask

    // Compare process, samples four clocks after valid rises
    initial begin : compare_proc
        int n;
        forever begin
            @(negedge clk);
            if (check_req) begin
                n = 0;
                while (!otp_rsp.valid && (n < 20)) begin
                    @(negedge clk);
                    n++;
                end
                if (!otp_rsp.valid) begin
                    $display("Timeout: valid never rose for the pending check");
                    err_count++;
                end
                repeat (4) @(posedge clk);
                @(negedge clk);
                check_sec_state(security_state, exp_sec, "settled");
                check_enable(soc_dft_en, exp_dft, "soc dft");
                check_enable(soc_hw_debug_en, exp_hw, "soc hw debug");
                check_error(state_error, err_model, "settled");
                check_req = 1'b0;
            end
        end
    end

    initial begin : stimulus
        logic [63:0] level;
        lc_tx_e      dcode;
        lc_tx_e      hcode;
        clk            = 1'b0;
        rst_n          <= 1'b0;
        mask_wr        <= '0;
        unlock_level   <= '0;
        fatal_err      <= '0;
        otp_req        <= '0;
        otp_rsp        <= '0;
        lc_dft_en      <= LcTxOff;
        lc_hw_debug_en <= LcTxOff;
        manuf_dbg_en   <= 1'b0;
        lfsr_q       = 16'd92;
        dft_mask_m   = '0;
        dbg_mask_m   = '0;
        cltap_mask_m = '0;
        err_model    = 1'b0;
        check_req    = 1'b0;
        err_count    = 0;
        err_mark     = 0;
        test_count   = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_locked("after reset");
        check_error(state_error, 1'b0, "after reset");
        finish_test("reset defaults");

        for (int i = 0; i <= int'(LcStInvalid); i++) begin
            run_case(lc_state_e'(i), 1'b0, '0, LcTxOff, LcTxOff);
            end_case();
        end
        finish_test("lifecycle table");

        run_case(LcStDev, 1'b1, '0, LcTxOff, LcTxOff);
        end_case();
        write_mask(DBG_MASK_LO, rand_bits(64));
        level = dbg_mask_m & rand_bits(64);
        run_case(LcStProd, 1'b0, level, LcTxOff, LcTxOff);
        end_case();
        run_case(LcStProd, 1'b0, ~dbg_mask_m, LcTxOff, LcTxOff);
        end_case();
        finish_test("manufacturing and production unlock");

        for (int i = 0; i < 6; i++) begin
            write_mask(DFT_MASK_LO, rand_bits(64) & rand_bits(64));
            write_mask(CLTAP_MASK_LO, rand_bits(64) & rand_bits(64));
            level = rand_bits(64) & rand_bits(64) & rand_bits(64);
            dcode = rand_bits(1) ? LcTxOn : lc_tx_e'(rand_bits(4));
            hcode = rand_bits(1) ? LcTxOn : lc_tx_e'(rand_bits(4));
            run_case(LcStRaw, 1'b0, level, dcode, hcode);
            end_case();
        end
        // Exact On decode with no mask hit
        run_case(LcStRaw, 1'b0, '0, LcTxOn, lc_tx_e'(4'b0100));
        end_case();
        run_case(LcStRaw, 1'b0, '0, lc_tx_e'(4'b0111), LcTxOn);
        end_case();
        finish_test("soc enables");

        run_case(LcStRma, 1'b0, '0, LcTxOff, LcTxOff);
        @(posedge clk);
        otp_req <= '{req: 1'b1, state: LcStScrap};
        wait_locked("scrap request");
        @(posedge clk);
        otp_req <= '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_sec_state(security_state, LOCKED_PROD, "scrap request held");
        end_case();
        finish_test("scrap request");

        write_reg(FATAL_EN, 32'h0000_00fb);
        @(posedge clk);
        fatal_err <= 8'h04;
        @(posedge clk);
        fatal_err <= 8'h00;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_error(state_error, 1'b0, "disabled source");
        run_case(LcStRma, 1'b0, '0, LcTxOff, LcTxOff);
        @(posedge clk);
        fatal_err <= 8'h01;
        @(posedge clk);
        fatal_err <= 8'h00;
        err_model = 1'b1;
        wait_locked("fatal error");
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_sec_state(security_state, LOCKED_PROD, "fatal error held");
        check_error(state_error, 1'b1, "after source drop");
        end_case();
        finish_test("fatal error");

        $display("%0d tests, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
